//--- hdl/mpbuffer_params.svh
/* message buffer sizing
   flit width, FIFO depth, channel count and the register map of a
   channel window */

`ifndef MPBUFFER_PARAMS_SVH
`define MPBUFFER_PARAMS_SVH

`define MPB_FLIT_WIDTH  32      // payload bits per flit
`define MPB_SIZE        16      // entries per FIFO
`define MPB_N           2       // number of channels

// channel k sits at k * 2**MPB_ADDR_CH_LSB
`define MPB_ADDR_CH_LSB 13

`define MPB_REG_DATA    32'h0   // flit data, push on write, pop on read
`define MPB_REG_SIZE    32'h4   // arm send on write, packet length on read
`define MPB_REG_IRQEN   32'h8   // bit 0 enables the receive interrupt

`endif

//--- hdl/mpbuffer_pkg.sv
/* message buffer types
   flit, packet length and the generic bus request/response */

`default_nettype none

`include "mpbuffer_params.svh"

package mpbuffer_pkg;

   typedef struct packed {
      logic                       last;   // final flit of a packet
      logic [`MPB_FLIT_WIDTH-1:0] data;   // opaque payload
   } flit_t;

   typedef logic [15:0] pkt_len_t;        // length in flits, 0 = no packet

   typedef struct packed {
      logic        en;                    // request strobe
      logic        we;                    // 1 = write
      logic [31:0] addr;
      logic [31:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        ack;                   // done, single pulse
      logic        err;                   // refused, single pulse
   } bus_rsp_t;

endpackage

`default_nettype wire

//--- hdl/msg_fifo.sv
/* msg_fifo
   first-word-fall-through ring buffer, payload type set by parameter */

`default_nettype none
`timescale 1ns/1ps

module msg_fifo #(
   parameter type T     = logic [31:0],
   parameter int  DEPTH = 16
) (
   input  wire logic clk,
   input  wire logic rst_n_i,
   input  wire logic push_i,
   input  wire logic pop_i,
   input  wire T     din_i,
   output T          dout_o,
   output logic      empty_o,
   output logic      full_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

   T              mem [DEPTH];    // storage
   logic [AW-1:0] wr_ptr;         // next free slot
   logic [AW-1:0] rd_ptr;         // head entry
   logic [AW:0]   count;          // entries held

   assign empty_o = (count == '0);
   assign full_o  = (count == (AW+1)'(DEPTH));
   assign dout_o  = mem[rd_ptr];  // head always visible

   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;  // wrap at depth
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // both or neither
         endcase
      end
   end

   // callers must check full/empty before acting
   assert property (@(posedge clk) disable iff (!rst_n_i) !(push_i && full_o));
   assert property (@(posedge clk) disable iff (!rst_n_i) !(pop_i && empty_o));

endmodule

`default_nettype wire

//--- hdl/mpbuffer_endpoint.sv
/* mpbuffer_endpoint
   one channel: send and receive FIFOs, register decode, bus errors
   and the receive interrupt enable */

`default_nettype none
`timescale 1ns/1ps

`include "mpbuffer_params.svh"

module mpbuffer_endpoint
   import mpbuffer_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n_i,
   input  wire logic     sel_i,            // one-cycle accept strobe from core
   input  wire bus_req_t req_i,
   output bus_rsp_t      rsp_o,            // combinational, core registers it
   output logic          busy_o,           // request cannot be taken yet
   output flit_t         noc_out_flit_o,
   output logic          noc_out_valid_o,
   input  wire logic     noc_out_ready_i,
   input  wire flit_t    noc_in_flit_i,
   input  wire logic     noc_in_valid_i,
   output logic          noc_in_ready_o,
   output logic          irq_o
);

   typedef logic [`MPB_ADDR_CH_LSB-1:0] off_t;

   localparam off_t OFF_DATA  = off_t'(`MPB_REG_DATA);
   localparam off_t OFF_SIZE  = off_t'(`MPB_REG_SIZE);
   localparam off_t OFF_IRQEN = off_t'(`MPB_REG_IRQEN);

   off_t     offset;
   logic     is_data;
   logic     is_size;
   logic     is_irqen;
   logic     bad;                 // request refused with err
   logic     wr_data;
   logic     wr_size;
   logic     wr_irqen;
   logic     rd_data;
   logic     take_pkt;            // size read moves head packet to readout
   pkt_len_t size_val;
   pkt_len_t send_rem;            // flits still owed to the armed send
   pkt_len_t rx_cnt;              // flits of the incoming packet so far
   pkt_len_t rd_rem;              // words left in readout
   logic     irq_en;
   flit_t    send_din;
   logic     send_empty;
   logic     send_full;
   flit_t    rx_head;
   logic     rx_push;
   logic     rx_full;
   pkt_len_t len_head;
   logic     len_push;
   logic     len_empty;
   logic     len_full;

   // register decode
   assign offset   = req_i.addr[`MPB_ADDR_CH_LSB-1:0];
   assign is_data  = (offset == OFF_DATA);
   assign is_size  = (offset == OFF_SIZE);
   assign is_irqen = (offset == OFF_IRQEN);

   assign bad = ~(is_data | is_size | is_irqen)                 // unmapped offset
              | (req_i.we & is_data & (send_rem == '0))         // nothing armed
              | (req_i.we & is_size & (send_rem != '0))         // already armed
              | (~req_i.we & is_data & (rd_rem == '0));         // readout empty

   assign wr_data  = sel_i & ~bad & req_i.we & is_data;
   assign wr_size  = sel_i & ~bad & req_i.we & is_size;
   assign wr_irqen = sel_i & ~bad & req_i.we & is_irqen;
   assign rd_data  = sel_i & ~bad & ~req_i.we & is_data;
   assign take_pkt = sel_i & ~req_i.we & is_size & (rd_rem == '0) & ~len_empty;

   // stall data writes while send FIFO is full
   assign busy_o = req_i.en & req_i.we & is_data & (send_rem != '0) & send_full;

   // unfinished readout wins over a fresh packet
   assign size_val = (rd_rem != '0) ? rd_rem : (len_empty ? '0 : len_head);

   always_comb begin
      rsp_o = '0;
      if (is_data) begin
         rsp_o.rdata = rx_head.data;
      end else if (is_size) begin
         rsp_o.rdata = 32'(size_val);
      end else if (is_irqen) begin
         rsp_o.rdata = 32'(irq_en);
      end
      rsp_o.err = sel_i & bad;
      rsp_o.ack = sel_i & ~bad;
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         send_rem <= '0;
         rx_cnt   <= '0;
         rd_rem   <= '0;
         irq_en   <= 1'b0;
      end else begin
         if (wr_size) begin
            send_rem <= req_i.wdata[15:0];           // zero arms nothing
         end else if (wr_data) begin
            send_rem <= send_rem - 1'b1;
         end
         if (rx_push) begin
            rx_cnt <= noc_in_flit_i.last ? '0 : rx_cnt + 1'b1;
         end
         if (take_pkt) begin
            rd_rem <= len_head;
         end else if (rd_data) begin
            rd_rem <= rd_rem - 1'b1;
         end
         if (wr_irqen) begin
            irq_en <= req_i.wdata[0];
         end
      end
   end

   // send path
   assign send_din.last   = (send_rem == 16'd1);   // L-th flit of the armed send
   assign send_din.data   = req_i.wdata;
   assign noc_out_valid_o = ~send_empty;

   msg_fifo #(.T(flit_t), .DEPTH(`MPB_SIZE)) u_send_fifo (
      .clk, .rst_n_i,
      .push_i (wr_data),
      .pop_i  (noc_out_valid_o & noc_out_ready_i),
      .din_i  (send_din),
      .dout_o (noc_out_flit_o),
      .empty_o(send_empty),
      .full_o (send_full)
   );

   // receive path, length queued only once the last flit is in
   assign noc_in_ready_o = ~rx_full & ~len_full;
   assign rx_push        = noc_in_valid_i & noc_in_ready_o;
   assign len_push       = rx_push & noc_in_flit_i.last;

   msg_fifo #(.T(flit_t), .DEPTH(`MPB_SIZE)) u_rx_fifo (
      .clk, .rst_n_i,
      .push_i (rx_push),
      .pop_i  (rd_data),
      .din_i  (noc_in_flit_i),
      .dout_o (rx_head),
      .empty_o(),
      .full_o (rx_full)
   );

   msg_fifo #(.T(pkt_len_t), .DEPTH(`MPB_SIZE)) u_len_fifo (
      .clk, .rst_n_i,
      .push_i (len_push),
      .pop_i  (take_pkt),
      .din_i  (rx_cnt + 1'b1),                     // count includes the last flit
      .dout_o (len_head),
      .empty_o(len_empty),
      .full_o (len_full)
   );

   assign irq_o = ~len_empty & irq_en;             // complete packet waiting

   // stalled flit must stay put until the network takes it
   assert property (@(posedge clk) disable iff (!rst_n_i)
      noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

`default_nettype wire

//--- hdl/mpbuffer.sv
/* mpbuffer core
   generic bus slave over MPB_N endpoints, channel decode,
   registered response and combined interrupt */

`default_nettype none
`timescale 1ns/1ps

`include "mpbuffer_params.svh"

module mpbuffer
   import mpbuffer_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     rst_n_i,
   input  wire bus_req_t                 bus_req_i,
   output bus_rsp_t                      bus_rsp_o,
   output flit_t [`MPB_N-1:0]            noc_out_flit_o,
   output logic [`MPB_N-1:0]             noc_out_valid_o,
   input  wire logic [`MPB_N-1:0]        noc_out_ready_i,
   input  wire flit_t [`MPB_N-1:0]       noc_in_flit_i,
   input  wire logic [`MPB_N-1:0]        noc_in_valid_i,
   output logic [`MPB_N-1:0]             noc_in_ready_o,
   output logic                          irq_o
);

   localparam int HW = 32 - `MPB_ADDR_CH_LSB;               // channel index bits
   localparam int CW = (`MPB_N > 1) ? $clog2(`MPB_N) : 1;

   logic [HW-1:0]         ch_idx;
   logic [CW-1:0]         ch;
   logic                  in_range;
   logic                  blank;      // response cycle, held request ignored
   logic                  accept;
   logic                  oor;        // out-of-range channel
   logic [`MPB_N-1:0]     ep_busy;
   logic [`MPB_N-1:0]     ep_irq;
   bus_rsp_t [`MPB_N-1:0] ep_rsp;

   assign ch_idx   = bus_req_i.addr[31:`MPB_ADDR_CH_LSB];
   assign ch       = ch_idx[CW-1:0];
   assign in_range = (ch_idx < HW'(`MPB_N));
   assign blank    = bus_rsp_o.ack | bus_rsp_o.err;
   assign accept   = bus_req_i.en & ~blank & in_range & ~ep_busy[ch];  // wait on busy
   assign oor      = bus_req_i.en & ~blank & ~in_range;

   for (genvar k = 0; k < `MPB_N; k++) begin : g_ep
      mpbuffer_endpoint u_ep (
         .clk,
         .rst_n_i,
         .sel_i          (accept & (ch == CW'(k))),
         .req_i          (bus_req_i),
         .rsp_o          (ep_rsp[k]),
         .busy_o         (ep_busy[k]),
         .noc_out_flit_o (noc_out_flit_o[k]),
         .noc_out_valid_o(noc_out_valid_o[k]),
         .noc_out_ready_i(noc_out_ready_i[k]),
         .noc_in_flit_i  (noc_in_flit_i[k]),
         .noc_in_valid_i (noc_in_valid_i[k]),
         .noc_in_ready_o (noc_in_ready_o[k]),
         .irq_o          (ep_irq[k])
      );
   end

   // response lands one cycle after accept
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bus_rsp_o <= '0;
      end else if (accept) begin
         bus_rsp_o <= ep_rsp[ch];
      end else if (oor) begin
         bus_rsp_o <= '{rdata: '0, ack: 1'b0, err: 1'b1};
      end else begin
         bus_rsp_o <= '0;                         // pulses last one cycle
      end
   end

   assign irq_o = |ep_irq;

   // endpoint and range decode never answer together
   assert property (@(posedge clk) disable iff (!rst_n_i)
      !(bus_rsp_o.ack && bus_rsp_o.err));

endmodule

`default_nettype wire

//--- hdl/mpbuffer_wb.sv
/* mpbuffer_wb
   Wishbone slave top level, maps classic cycles onto the generic bus */

`default_nettype none
`timescale 1ns/1ps

`include "mpbuffer_params.svh"

module mpbuffer_wb
   import mpbuffer_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     rst_n_i,
   input  wire logic [31:0]              wb_adr_i,
   input  wire logic                     wb_we_i,
   input  wire logic                     wb_cyc_i,
   input  wire logic                     wb_stb_i,
   input  wire logic [31:0]              wb_dat_i,
   output logic [31:0]                   wb_dat_o,
   output logic                          wb_ack_o,
   output logic                          wb_err_o,
   output flit_t [`MPB_N-1:0]            noc_out_flit_o,
   output logic [`MPB_N-1:0]             noc_out_valid_o,
   input  wire logic [`MPB_N-1:0]        noc_out_ready_i,
   input  wire flit_t [`MPB_N-1:0]       noc_in_flit_i,
   input  wire logic [`MPB_N-1:0]        noc_in_valid_i,
   output logic [`MPB_N-1:0]             noc_in_ready_o,
   output logic                          irq_o
);

   bus_req_t bus_req;
   bus_rsp_t bus_rsp;

   // cycle and strobe together mark a live request
   assign bus_req = '{en: wb_cyc_i & wb_stb_i, we: wb_we_i, addr: wb_adr_i, wdata: wb_dat_i};

   assign wb_dat_o = bus_rsp.rdata;
   assign wb_ack_o = bus_rsp.ack;
   assign wb_err_o = bus_rsp.err;

   mpbuffer u_buffer (
      .clk, .rst_n_i,
      .bus_req_i(bus_req),
      .bus_rsp_o(bus_rsp),
      .noc_out_flit_o, .noc_out_valid_o, .noc_out_ready_i,
      .noc_in_flit_i, .noc_in_valid_i, .noc_in_ready_o,
      .irq_o
   );

endmodule

`default_nettype wire

//--- bench/mpbuffer_tb.sv
/* mpbuffer testbench
   drives Wishbone and both NoC ports, models the expected flits and
   packet lengths, and checks every response of the buffer */

`default_nettype none
`timescale 1ns/1ps

`include "mpbuffer_params.svh"

module mpbuffer_tb
   import mpbuffer_pkg::*;
();

   localparam int SEND_PKTS   = 8;                 // packets per send test
   localparam int MAX_LEN     = 8;                 // longest random packet
   localparam int BIG_LEN     = 40;                // overruns the send FIFO
   localparam int RX_LEN      = 8;                 // 3 of these overrun the rx FIFO
   localparam int TOTAL_FLITS = 2*SEND_PKTS*MAX_LEN + BIG_LEN + 3*MAX_LEN + 3*RX_LEN + 3;
   localparam int LIMIT       = 1000;              // per wait loop, in cycles

   logic               clk;
   logic               rst_n;
   logic [31:0]        wb_adr;
   logic               wb_we;
   logic               wb_cyc;
   logic               wb_stb;
   logic [31:0]        wb_dat_w;
   logic [31:0]        wb_dat_r;
   logic               wb_ack;
   logic               wb_err;
   flit_t [`MPB_N-1:0] noc_out_flit;
   logic [`MPB_N-1:0]  noc_out_valid;
   logic [`MPB_N-1:0]  noc_out_ready;
   flit_t [`MPB_N-1:0] noc_in_flit;
   logic [`MPB_N-1:0]  noc_in_valid;
   logic [`MPB_N-1:0]  noc_in_ready;
   logic               irq;

   int          ready_pct;                         // chance of noc_out ready per cycle
   int          checks;
   int          flit_errs;
   int          word_errs;
   int          flag_errs;
   int          other_errs;
   flit_t       exp_out [`MPB_N][$];               // flits the send port still owes
   logic [31:0] exp_in_words [`MPB_N][$];          // injected words not yet read back
   int          exp_in_lens [`MPB_N][$];

   mpbuffer_wb uut (
      .clk, .rst_n_i(rst_n),
      .wb_adr_i(wb_adr), .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .noc_out_flit_o(noc_out_flit), .noc_out_valid_o(noc_out_valid),
      .noc_out_ready_i(noc_out_ready), .noc_in_flit_i(noc_in_flit),
      .noc_in_valid_i(noc_in_valid), .noc_in_ready_o(noc_in_ready), .irq_o(irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                       // 4 ns period
   end

   initial begin
      repeat (TOTAL_FLITS * 40 + 2000) @(posedge clk);
      $display("watchdog expired, the run did not finish in time");
      $display("Test failed");
      $finish;
   end

   always @(negedge clk) begin                     // random back-pressure on send
      for (int k = 0; k < `MPB_N; k++) begin
         noc_out_ready[k] = ($urandom_range(99) < ready_pct);
      end
   end

   always @(posedge clk) begin                     // every accepted flit vs the model
      for (int k = 0; k < `MPB_N; k++) begin
         if (rst_n && noc_out_valid[k] && noc_out_ready[k]) begin
            if (exp_out[k].size() == 0) begin
               $display("flit appeared on channel %0d with none expected there", k);
               other_errs++;
            end else begin
               check_flit($sformatf("noc_out ch%0d", k), exp_out[k].pop_front(), noc_out_flit[k]);
            end
         end
      end
   end

   // the L-th flit of a packet carries the last flag
   function automatic flit_t expected_flit(input logic [31:0] data, input int pos, input int len);
      flit_t f;
      f.data = data;
      f.last = (pos == len - 1);
      return f;
   endfunction

   function automatic logic [31:0] reg_addr(input int ch, input logic [31:0] off);
      return (32'(ch) << `MPB_ADDR_CH_LSB) | off;  // 8 KiB window per channel
   endfunction

   function automatic int pending_flits();
      int s;
      s = 0;
      for (int k = 0; k < `MPB_N; k++) begin
         s += exp_out[k].size();
      end
      return s;
   endfunction

   task automatic check_flit(input string name, input flit_t exp, input flit_t act);
      checks++;
      if (exp !== act) begin
         $display("Error %s: expected last %0b data %h, actual last %0b data %h",
                  name, exp.last, exp.data, act.last, act.data);
         flit_errs++;
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         word_errs++;
      end
   endtask

   task automatic check_flag(input string name, input bit exp, input bit act);
      checks++;
      if (exp !== act) begin
         $display("Error %s: expected %0b, actual %0b", name, exp, act);
         flag_errs++;
      end
   endtask

   // one classic cycle, held until ack or err, lat counts cycles waited
   task automatic bus_cycle(input bit we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output bit ack, output bit err,
                            output int lat);
      lat = 0;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = addr;
      wb_dat_w = wdata;
      do begin
         @(negedge clk);
         lat++;
      end while (!wb_ack && !wb_err && lat < LIMIT);
      if (!wb_ack && !wb_err) begin
         $display("bus access to %h got neither ack nor err", addr);
         other_errs++;
      end
      rdata  = wb_dat_r;
      ack    = wb_ack;
      err    = wb_err;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input int ch, input logic [31:0] off, input logic [31:0] data,
                            input string name);
      logic [31:0] rdata;
      bit          ack;
      bit          err;
      int          lat;
      bus_cycle(1'b1, reg_addr(ch, off), data, rdata, ack, err, lat);
      check_flag({name, " ack"}, 1'b1, ack);
   endtask

   task automatic expect_err(input string name, input bit we, input logic [31:0] addr);
      logic [31:0] rdata;
      bit          ack;
      bit          err;
      int          lat;
      bus_cycle(we, addr, 32'h2, rdata, ack, err, lat);
      check_flag({name, " ack"}, 1'b0, ack);
      check_flag({name, " err"}, 1'b1, err);
   endtask

   task automatic push_words(input int ch, input int len, input string name, output int max_lat);
      logic [31:0] w;
      logic [31:0] rdata;
      bit          ack;
      bit          err;
      int          lat;
      max_lat = 0;
      for (int i = 0; i < len; i++) begin
         w = $urandom;
         exp_out[ch].push_back(expected_flit(w, i, len));
         bus_cycle(1'b1, reg_addr(ch, `MPB_REG_DATA), w, rdata, ack, err, lat);
         check_flag({name, " data ack"}, 1'b1, ack);
         if (lat > max_lat) begin
            max_lat = lat;                         // above 1 means busy held it
         end
      end
   endtask

   task automatic send_packet(input int ch, input int len, input string name, output int max_lat);
      write_reg(ch, `MPB_REG_SIZE, 32'(len), {name, " size"});
      push_words(ch, len, name, max_lat);
   endtask

   task automatic wait_send_drained(input string name);
      int n;
      n = 0;
      while (pending_flits() != 0 && n < 5 * LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (pending_flits() != 0) begin
         $display("%s: %0d flits never left the send port", name, pending_flits());
         other_errs++;
      end
   endtask

   // valid may drop only before a new flit, never while one waits
   task automatic inject_packet(input int ch, input int len, input bit gaps);
      logic [31:0] w;
      exp_in_lens[ch].push_back(len);
      for (int i = 0; i < len; i++) begin
         w = $urandom;
         exp_in_words[ch].push_back(w);
         @(negedge clk);
         while (gaps && $urandom_range(3) == 0) begin
            noc_in_valid[ch] = 1'b0;
            @(negedge clk);
         end
         noc_in_flit[ch]  = expected_flit(w, i, len);
         noc_in_valid[ch] = 1'b1;
         while (!noc_in_ready[ch]) begin     // ready sampled away from the edge
            @(negedge clk);
         end
         @(posedge clk);                     // transfer edge
      end
      @(negedge clk);
      noc_in_valid[ch] = 1'b0;
   endtask

   task automatic read_packet(input int ch, input string name);
      logic [31:0] rdata;
      bit          ack;
      bit          err;
      int          lat;
      int          len;
      len = (exp_in_lens[ch].size() != 0) ? exp_in_lens[ch].pop_front() : 0;
      bus_cycle(1'b0, reg_addr(ch, `MPB_REG_SIZE), '0, rdata, ack, err, lat);
      check_flag({name, " size ack"}, 1'b1, ack);
      check_word({name, " size"}, 32'(len), rdata);
      for (int i = 0; i < len; i++) begin
         bus_cycle(1'b0, reg_addr(ch, `MPB_REG_DATA), '0, rdata, ack, err, lat);
         check_flag({name, " data ack"}, 1'b1, ack);
         check_word({name, " data"}, exp_in_words[ch].pop_front(), rdata);
      end
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      while (!irq && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!irq) begin
         $display("irq did not rise although a packet was stored");
         other_errs++;
      end
   endtask

   task automatic wait_rx_full(input int ch);
      int n;
      n = 0;
      while (noc_in_ready[ch] && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      check_flag("rx ready when full", 1'b0, noc_in_ready[ch]);
   endtask

   initial begin
      logic [31:0] rdata;
      bit          ack;
      bit          err;
      int          lat;
      void'($urandom(32'h4bebd802));
      rst_n         = 1'b0;
      wb_adr        = '0;
      wb_we         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_dat_w      = '0;
      noc_out_ready = '0;
      noc_in_flit   = '0;
      noc_in_valid  = '0;
      ready_pct     = 100;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      for (int p = 0; p < SEND_PKTS; p++) begin   // plain sends, channels alternate
         send_packet(p % `MPB_N, $urandom_range(MAX_LEN, 1), "send", lat);
      end
      wait_send_drained("send");

      ready_pct = 12;                              // drains slower than the bus fills
      send_packet(0, BIG_LEN, "send full", lat);
      if (lat <= 1) begin
         $display("no data write ever stalled on a full send FIFO");
         other_errs++;
      end
      ready_pct = 50;
      for (int p = 0; p < SEND_PKTS; p++) begin
         send_packet(p % `MPB_N, $urandom_range(MAX_LEN, 1), "send backpressure", lat);
      end
      wait_send_drained("send backpressure");
      ready_pct = 100;

      write_reg(0, `MPB_REG_IRQEN, 32'h1, "irqen ch0");
      write_reg(1, `MPB_REG_IRQEN, 32'h0, "irqen ch1");
      bus_cycle(1'b0, reg_addr(0, `MPB_REG_IRQEN), '0, rdata, ack, err, lat);
      check_word("irqen readback", 32'h1, rdata);
      check_flag("irq idle", 1'b0, irq);
      inject_packet(1, $urandom_range(MAX_LEN, 1), 1'b0);
      check_flag("irq disabled channel", 1'b0, irq);
      read_packet(1, "rx ch1");
      inject_packet(0, $urandom_range(MAX_LEN, 1), 1'b0);
      inject_packet(0, $urandom_range(MAX_LEN, 1), 1'b0);
      check_flag("irq enabled channel", 1'b1, irq);
      read_packet(0, "rx ch0 first");
      check_flag("irq second packet", 1'b1, irq);
      read_packet(0, "rx ch0 second");
      check_flag("irq after last packet", 1'b0, irq);

      write_reg(1, `MPB_REG_IRQEN, 32'h1, "irqen ch1");
      fork
         for (int p = 0; p < 3; p++) inject_packet(1, RX_LEN, 1'b1);
         begin
            wait_rx_full(1);
            for (int p = 0; p < 3; p++) begin
               wait_irq();
               read_packet(1, "rx overrun");
            end
         end
      join
      check_flag("irq after overrun", 1'b0, irq);

      expect_err("data write unarmed", 1'b1, reg_addr(0, `MPB_REG_DATA));
      write_reg(1, `MPB_REG_SIZE, 32'd3, "arm send");
      expect_err("size write armed", 1'b1, reg_addr(1, `MPB_REG_SIZE));
      push_words(1, 3, "armed send", lat);
      expect_err("data read empty", 1'b0, reg_addr(0, `MPB_REG_DATA));
      expect_err("channel out of range", 1'b0, reg_addr(`MPB_N, `MPB_REG_SIZE));
      bus_cycle(1'b0, reg_addr(0, `MPB_REG_SIZE), '0, rdata, ack, err, lat);
      check_flag("size read idle ack", 1'b1, ack);
      check_word("size read idle", 32'h0, rdata);
      wait_send_drained("armed send");

      $display("checks %0d, errors: flit %0d, word %0d, flag %0d, other %0d",
               checks, flit_errs, word_errs, flag_errs, other_errs);
      if (flit_errs + word_errs + flag_errs + other_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/mpbuffer_pkg.sv
hdl/msg_fifo.sv
hdl/mpbuffer_endpoint.sv
hdl/mpbuffer.sv
hdl/mpbuffer_wb.sv
bench/mpbuffer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the mpbuffer testbench with Verilator, run it and scan the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module mpbuffer_tb -f files.f -o mpbuffer_sim \
   || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/mpbuffer_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }
